// ==== testbench/env_patterns.txt ====
# test ar dr sl rr tl ksr ksl egt am dam nts fnum block key(1 on 2 off 3 both) ticks kind exp
# kind 0 idle 1 hold 2 rising 3 sustain 4 release 5 tremolo, tl ff randomizes tl and ksl
1 0 0 0 0 00 0 0 0 0 0 0 000 0 0 10 0 1ff
2 f 0 f 0 0a 0 3 1 0 0 0 3ff 7 1 2 1 0
3 f 0 f 0 ff 0 0 1 0 0 0 200 4 1 2 1 0
4 f 0 4 0 02 0 1 1 0 0 0 200 4 1 2 1 0
5 f c 4 0 02 0 1 1 0 0 0 200 4 0 150 2 0
6 f c 4 0 02 0 1 1 0 0 0 200 4 0 50 3 0
7 f c 4 e 02 0 1 0 0 0 0 200 4 0 250 4 0
8 f 0 f 0 02 0 1 1 0 0 0 200 4 1 2 1 0
9 f 0 f e 02 0 1 1 0 0 0 200 4 2 250 4 0
10 f 0 0 0 00 0 0 1 0 0 0 200 4 1 2 1 0
11 f 0 0 0 00 0 0 1 1 1 0 200 4 0 400 5 0
12 f 0 0 0 00 0 0 1 1 0 0 200 4 0 400 5 0
13 f 0 0 f 00 0 0 1 0 0 0 200 4 2 200 4 0
14 f 0 f 0 0a 0 3 1 0 0 0 3ff 7 3 2 1 0

// ==== src.f ====
common/opl3_env_pkg.sv
common/op_param_if.sv
envelope_generator/env_decode.sv
envelope_generator/env_rate_counter.sv
envelope_generator/env_state_machine.sv
envelope_generator/env_output_level.sv
rtl/envelope_top.sv
testbench/env_checker.sv
testbench/tb_envelope.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_envelope
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_envelope.sv ====
// ----------------------------------------------------------------------
// testbench top with clock, reset and sample tick generator
// pattern file reader, stimulus driver and cycle limit
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_envelope;
    import opl3_env_pkg::*;

    logic clk, arst_n, sample_clk_en, key_on_pulse, key_off_pulse;
    env_field_t ar, dr, sl, rr;
    tl_field_t  tl;
    logic       ksr, egt, am, dam, nts;
    ksl_field_t ksl;
    fnum_t      fnum;
    mult_t      mult;
    block_t     block;
    env_level_t env;
    int         test_num, test_count, error_count;
    logic [2:0] check_kind;
    logic [8:0] exp_val;
    logic       test_active, test_end;
    int         seed, cycles, cycle_limit, fd, tick_total;
    int         f[18];  // test ar dr sl rr tl ksr ksl egt am dam nts fnum block key ticks kind exp
    string      line;

    envelope_top UUT (.*);

    env_checker u_checker (.clk(clk), .sample_clk_en(sample_clk_en), .env(env), .tl(tl),
        .ksl(ksl), .fnum(fnum), .block(block), .sl(sl), .dam(dam), .test_num(test_num),
        .check_kind(check_kind), .exp_val(exp_val), .test_active(test_active),
        .test_end(test_end), .test_count(test_count), .error_count(error_count));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sample strobe every 4 clocks
    initial begin
        int phase;
        phase = 0;
        sample_clk_en = 1'b0;
        forever begin
            @(posedge clk);
            #1 sample_clk_en = (phase == 3);
            phase = (phase + 1) % 4;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // returns 1 when a record was read and skips comment and blank lines
    function automatic bit read_record(int fh);
        while (!$feof(fh)) begin
            line = "";
            void'($fgets(line, fh));
            if (line.len() > 1 && line.getc(0) != "#") begin
                void'($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17]));
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic wait_ticks(int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (sample_clk_en) seen++;
        end
        #1;
    endtask

    initial begin
        {arst_n, key_on_pulse, key_off_pulse, ar, dr, sl, rr, tl, ksr, egt} = '0;
        {am, dam, nts, ksl, fnum, mult, block} = '0;
        {test_num, check_kind, exp_val, test_active, test_end} = '0;
        seed = 20976;
        cycles = 0;
        cycle_limit = 0;
        tick_total = 0;
        fd = $fopen("testbench/env_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while (read_record(fd)) tick_total += f[15];
            $fclose(fd);
            cycle_limit = tick_total * 4 + 200;
            fd = $fopen("testbench/env_patterns.txt", "r");
            repeat (5) @(posedge clk);
            #1 arst_n = 1'b1;
            while (read_record(fd)) begin
                @(posedge clk);
                #1;
                test_num = f[0];
                {ar, dr, sl, rr} = {f[1][3:0], f[2][3:0], f[3][3:0], f[4][3:0]};
                tl  = f[5][5:0];
                ksl = f[7][1:0];
                if (f[5] == 'hff) begin  // randomized level fields
                    tl  = tl_field_t'($random(seed));
                    ksl = ksl_field_t'($random(seed));
                end
                {ksr, egt, am, dam, nts} = {f[6][0], f[8][0], f[9][0], f[10][0], f[11][0]};
                fnum  = f[12][9:0];
                block = f[13][2:0];
                key_on_pulse  = f[14][0];
                key_off_pulse = f[14][1];
                check_kind  = f[16][2:0];
                exp_val     = f[17][8:0];
                test_active = 1'b1;
                @(posedge clk);
                #1 {key_on_pulse, key_off_pulse} = 2'b00;
                wait_ticks(f[15]);
                test_end = 1'b1;
                @(posedge clk);
                #1 test_end = 1'b0;
                test_active = 1'b0;
            end
            $fclose(fd);
            @(posedge clk);
            #1 $display("tests run %0d, errors %0d", test_count, error_count);
            if (error_count == 0)
                $display("NO ERRORS");
            else
                $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/env_checker.sv ====
// ----------------------------------------------------------------------
// envelope checker, watches the DUT ports on sample ticks,
// compares env against record expectations, counts tests and errors
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module env_checker (
    input  wire  clk,
    input  wire  sample_clk_en,
    input  wire  opl3_env_pkg::env_level_t env,
    input  wire  opl3_env_pkg::tl_field_t tl,
    input  wire  opl3_env_pkg::ksl_field_t ksl,
    input  wire  opl3_env_pkg::fnum_t fnum,
    input  wire  opl3_env_pkg::block_t block,
    input  wire  opl3_env_pkg::env_field_t sl,
    input  wire  dam,
    input  int   test_num,
    input  wire  [2:0] check_kind,  // 0 idle 1 hold 2 rising 3 sustain 4 release 5 tremolo
    input  wire  [8:0] exp_val,
    input  wire  test_active,
    input  wire  test_end,
    output int   test_count,
    output int   error_count
);
    import opl3_env_pkg::*;

    int   test_errors;
    int   prev_env;
    bit   have_prev;
    int   min_rel;
    int   max_rel;
    int   rel;
    int   expect_env;
    int   peak;

    // key scale attenuation, 0.1875 dB units, from the top four fnum bits
    function automatic int ksl_atten(fnum_t f, block_t b, ksl_field_t k);
        int table_val[16] = '{0, 32, 40, 45, 48, 51, 53, 55, 56, 58, 59, 60, 61, 62, 63, 64};
        int full;
        full = 4 * table_val[f[9:6]] - 32 * (8 - int'(b));
        if (full < 0)
            full = 0;
        case (k)
            2'd0:    return 0;
            2'd1:    return full / 2;  // 3 dB per octave
            2'd2:    return full / 4;
            default: return full;      // 6 dB per octave
        endcase
    endfunction

    task automatic report_value(string name, int expv, int actv);
        $display("FAILED test %0d %s expected %h got %h", test_num, name, expv, actv);
        test_errors++;
    endtask

    initial begin
        test_count  = 0;
        error_count = 0;
        test_errors = 0;
        have_prev   = 0;
        min_rel     = 1000;
        max_rel     = -1000;
    end

    always @(posedge clk) begin
        rel  = int'(env) - (4 * int'(tl) + ksl_atten(fnum, block, ksl));
        peak = dam ? int'(TREMOLO_DEEP_MAX) : int'(TREMOLO_SHALLOW_MAX);
        if (test_active && sample_clk_en) begin
            case (check_kind)
                3'd0: if (env != exp_val) report_value("env", exp_val, env);
                3'd2, 3'd4: if (have_prev && int'(env) < prev_env)
                    report_value("env (no fall)", prev_env, env);
                3'd3: if ((rel >>> 4) != int'(sl)) report_value("env level/16", sl, rel >>> 4);
                3'd5: begin
                    if (rel < 0 || rel > peak)
                        report_value("env tremolo part", peak, rel);
                    if (rel < min_rel) min_rel = rel;
                    if (rel > max_rel) max_rel = rel;
                end
                default: ;
            endcase
            prev_env  = int'(env);
            have_prev = 1;
        end
        if (test_end) begin
            expect_env = 4 * int'(tl) + ksl_atten(fnum, block, ksl);
            if (expect_env > 511)
                expect_env = 511;  // clamp at silence
            if (check_kind == 3'd1 && int'(env) != expect_env)
                report_value("env", expect_env, env);
            if (check_kind == 3'd4 && env != 9'h1ff)
                report_value("env", 9'h1ff, env);
            if (check_kind == 3'd5 && min_rel == max_rel) begin
                $display("test %0d: tremolo value never changed", test_num);
                test_errors++;
            end
            if (test_errors == 0)
                $display("test %0d passed", test_num);
            else
                $display("test %0d failed with %0d errors", test_num, test_errors);
            test_count++;
            error_count += test_errors;
            test_errors = 0;
            have_prev   = 0;
            min_rel     = 1000;
            max_rel     = -1000;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/envelope_top.sv ====
// ----------------------------------------------------------------------
// envelope_top, one operator envelope generator
// register fields into the parameter bundle, decode/execute/result
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module envelope_top (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  sample_clk_en,  // one cycle per sample
    input  wire  key_on_pulse,
    input  wire  key_off_pulse,
    input  wire  opl3_env_pkg::env_field_t ar,
    input  wire  opl3_env_pkg::env_field_t dr,
    input  wire  opl3_env_pkg::env_field_t sl,
    input  wire  opl3_env_pkg::env_field_t rr,
    input  wire  opl3_env_pkg::tl_field_t tl,
    input  wire  ksr,
    input  wire  egt,
    input  wire  am,
    input  wire  dam,
    input  wire  nts,
    input  wire  opl3_env_pkg::ksl_field_t ksl,
    input  wire  opl3_env_pkg::fnum_t fnum,
    input  wire  opl3_env_pkg::mult_t mult,
    input  wire  opl3_env_pkg::block_t block,
    output opl3_env_pkg::env_level_t env  // attenuation, 511 is silent
);
    import opl3_env_pkg::*;

    ksl_add_t                     ksl_add;
    logic [RATE_OFFSET_WIDTH-1:0] rate_offset;
    env_level_t                   env_raw;

    op_param_if params ();

    assign params.ar    = ar;
    assign params.dr    = dr;
    assign params.sl    = sl;
    assign params.rr    = rr;
    assign params.tl    = tl;
    assign params.ksr   = ksr;
    assign params.ksl   = ksl;
    assign params.egt   = egt;
    assign params.am    = am;
    assign params.dam   = dam;
    assign params.nts   = nts;
    assign params.fnum  = fnum;
    assign params.mult  = mult;
    assign params.block = block;

    env_decode u_decode (
        .params      (params),
        .ksl_add     (ksl_add),
        .rate_offset (rate_offset)
    );

    env_state_machine u_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .key_on_pulse  (key_on_pulse),
        .key_off_pulse (key_off_pulse),
        .params        (params),
        .rate_offset   (rate_offset),
        .env_raw       (env_raw)
    );

    env_output_level u_result (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .params        (params),
        .env_raw       (env_raw),
        .ksl_add       (ksl_add),
        .env           (env)
    );

endmodule

`default_nettype wire

// ==== envelope_generator/env_output_level.sv ====
// ----------------------------------------------------------------------
// env_output_level, tremolo triangle, attenuation sum with clamp
// at silence, registered envelope output
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module env_output_level (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  sample_clk_en,
    op_param_if.result params,
    input  wire  opl3_env_pkg::env_level_t env_raw,
    input  wire  opl3_env_pkg::ksl_add_t ksl_add,
    output opl3_env_pkg::env_level_t env
);
    import opl3_env_pkg::*;

    localparam int TICK_CNT_WIDTH = $clog2(TREMOLO_STEP_TICKS);
    localparam int SUM_WIDTH      = ENV_WIDTH + 2;  // raw + tl + ksl + tremolo

    logic [TICK_CNT_WIDTH-1:0] tick_cnt;
    logic                      am_step;
    logic                      am_up;   // triangle direction
    am_val_t                   am_val;
    am_val_t                   am_peak;
    logic [SUM_WIDTH-1:0]      env_sum;

    assign am_peak = params.dam ? TREMOLO_DEEP_MAX : TREMOLO_SHALLOW_MAX;
    assign am_step = sample_clk_en && (tick_cnt == TICK_CNT_WIDTH'(TREMOLO_STEP_TICKS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            am_val   <= '0;
            am_up    <= 1'b1;
        end else begin
            if (sample_clk_en)
                tick_cnt <= tick_cnt + 1'b1;  // wraps every step period
            if (am_val > am_peak) begin
                am_val <= am_peak;  // depth switched to shallow
                am_up  <= 1'b0;
            end else if (am_step) begin
                if (am_up && am_val >= am_peak) begin
                    am_up  <= 1'b0;
                    am_val <= am_val - 1'b1;
                end else if (!am_up && am_val == '0) begin
                    am_up  <= 1'b1;
                    am_val <= am_val + 1'b1;
                end else begin
                    am_val <= am_up ? am_val + 1'b1 : am_val - 1'b1;
                end
            end
        end
    end

    assign env_sum = SUM_WIDTH'(env_raw) + SUM_WIDTH'({params.tl, 2'b00})
                   + SUM_WIDTH'(ksl_add) + (params.am ? SUM_WIDTH'(am_val) : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            env <= ENV_SILENCE;
        else
            env <= (env_sum > SUM_WIDTH'(ENV_SILENCE)) ? ENV_SILENCE : env_sum[ENV_WIDTH-1:0];
    end

    a_am_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        $stable(params.dam) |-> am_val <= am_peak);

endmodule

`default_nettype wire

// ==== envelope_generator/env_state_machine.sv ====
// ----------------------------------------------------------------------
// attack/decay/sustain/release FSM
// per-state rate select and raw envelope level register
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module env_state_machine (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  sample_clk_en,
    input  wire  key_on_pulse,
    input  wire  key_off_pulse,
    op_param_if.execute params,
    input  wire  [opl3_env_pkg::RATE_OFFSET_WIDTH-1:0] rate_offset,
    output opl3_env_pkg::env_level_t env_raw
);
    import opl3_env_pkg::*;

    env_state_t     state;
    env_state_t     next_state;
    env_field_t     requested_rate;
    rate_overflow_t rate_counter_overflow;
    logic [11:0]    attack_prod;  // env_raw * overflow count
    logic [9:0]     attack_dec;
    logic [9:0]     grow_sum;     // decay/release sum before saturation

    env_rate_counter u_rate_counter (
        .clk                   (clk),
        .arst_n                (arst_n),
        .sample_clk_en         (sample_clk_en),
        .requested_rate        (requested_rate),
        .rate_offset           (rate_offset),
        .rate_counter_overflow (rate_counter_overflow)
    );

    always_comb begin
        case (state)
            ENV_ATTACK:  next_state = (env_raw == '0) ? ENV_DECAY : ENV_ATTACK;
            ENV_DECAY:   next_state = (env_raw[8:4] >= {1'b0, params.sl}) ? ENV_SUSTAIN
                                                                          : ENV_DECAY;
            ENV_SUSTAIN: next_state = params.egt ? ENV_SUSTAIN : ENV_RELEASE;
            default:     next_state = ENV_RELEASE;
        endcase
        case (state)
            ENV_ATTACK:  requested_rate = params.ar;
            ENV_DECAY:   requested_rate = params.dr;
            ENV_SUSTAIN: requested_rate = '0;  // hold
            default:     requested_rate = params.rr;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= ENV_RELEASE;
        else if (key_on_pulse)
            state <= ENV_ATTACK;  // key-on wins over key-off
        else if (key_off_pulse)
            state <= ENV_RELEASE;
        else
            state <= next_state;
    end

    assign attack_prod = env_raw * rate_counter_overflow;
    assign attack_dec  = 10'(attack_prod >> 3) + 10'd1;  // exponential approach to 0
    assign grow_sum    = {1'b0, env_raw} + 10'(rate_counter_overflow);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            env_raw <= ENV_SILENCE;
        end else if (sample_clk_en) begin
            if (state == ENV_ATTACK) begin
                if (params.ar == 4'd15)
                    env_raw <= '0;  // instant attack
                else if (rate_counter_overflow != '0)
                    env_raw <= (attack_dec >= {1'b0, env_raw}) ? '0 : env_raw - attack_dec[8:0];
            end else if (state == ENV_DECAY || state == ENV_RELEASE) begin
                env_raw <= (grow_sum > 10'(ENV_SILENCE)) ? ENV_SILENCE : grow_sum[8:0];
            end
        end
    end

    a_state_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(state));
    // growth stops at silence instead of wrapping past 511
    a_raw_saturates: assert property (@(posedge clk) disable iff (!arst_n)
        sample_clk_en && (state == ENV_DECAY || state == ENV_RELEASE)
        |=> env_raw >= $past(env_raw));
    a_raw_tick_only: assert property (@(posedge clk) disable iff (!arst_n)
        !sample_clk_en |=> $stable(env_raw));

endmodule

`default_nettype wire

// ==== envelope_generator/env_rate_counter.sv ====
// ----------------------------------------------------------------------
// env_rate_counter, effective rate from requested rate and key scale
// offset, carry count of the rate accumulator per sample tick
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module env_rate_counter (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  sample_clk_en,
    input  wire  opl3_env_pkg::env_field_t requested_rate,
    input  wire  [opl3_env_pkg::RATE_OFFSET_WIDTH-1:0] rate_offset,
    output opl3_env_pkg::rate_overflow_t rate_counter_overflow
);
    import opl3_env_pkg::*;

    localparam int SUM_WIDTH = RATE_COUNTER_WIDTH + RATE_OVERFLOW_WIDTH;

    logic [EFF_RATE_WIDTH-1:0]     rate_sum;   // 4*rate + offset, max 63
    logic [EFF_RATE_WIDTH-1:0]     eff_rate;
    logic [3:0]                    rate_shift;
    logic [2:0]                    rate_step;  // 4..7 mantissa
    logic [SUM_WIDTH-1:0]          step;
    logic [SUM_WIDTH-1:0]          next_sum;
    logic [RATE_COUNTER_WIDTH-1:0] counter;

    assign rate_sum = {requested_rate, 2'b00} + EFF_RATE_WIDTH'(rate_offset);

    always_comb begin
        if (requested_rate == '0)
            eff_rate = '0;  // zero rate holds the level
        else if (rate_sum > EFF_RATE_WIDTH'(EFF_RATE_MAX))
            eff_rate = EFF_RATE_WIDTH'(EFF_RATE_MAX);
        else
            eff_rate = rate_sum;
    end

    assign rate_shift = eff_rate[5:2];
    assign rate_step  = 3'd4 | {1'b0, eff_rate[1:0]};
    assign step       = (eff_rate == '0) ? '0 : (SUM_WIDTH'(rate_step) << rate_shift);
    assign next_sum   = SUM_WIDTH'(counter) + step;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            counter <= '0;
        else if (sample_clk_en)
            counter <= next_sum[RATE_COUNTER_WIDTH-1:0];  // keep the fraction
    end

    // carries out of the top bit, only on the tick itself
    assign rate_counter_overflow = sample_clk_en ? next_sum[SUM_WIDTH-1:RATE_COUNTER_WIDTH]
                                                 : '0;

endmodule

`default_nettype wire

// ==== envelope_generator/env_decode.sv ====
// ----------------------------------------------------------------------
// key scale level table lookup and scaling
// key scale rate offset from block and keyboard split
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module env_decode (
    op_param_if.decode params,
    output opl3_env_pkg::ksl_add_t ksl_add,
    output logic [opl3_env_pkg::RATE_OFFSET_WIDTH-1:0] rate_offset
);
    import opl3_env_pkg::*;

    logic [6:0]       ksl_rom_val;  // top fnum bits attenuation in 0.75 dB units
    logic signed [9:0] ksl_base;    // rom*4 less 32 per octave below 7
    logic [7:0]       ksl_full;     // 6 dB/octave scale clamped at 0
    logic             split_bit;
    logic [3:0]       key_code;

    always_comb begin
        case (params.fnum[9:6])
            4'd0:    ksl_rom_val = 7'd0;
            4'd1:    ksl_rom_val = 7'd32;
            4'd2:    ksl_rom_val = 7'd40;
            4'd3:    ksl_rom_val = 7'd45;
            4'd4:    ksl_rom_val = 7'd48;
            4'd5:    ksl_rom_val = 7'd51;
            4'd6:    ksl_rom_val = 7'd53;
            4'd7:    ksl_rom_val = 7'd55;
            4'd8:    ksl_rom_val = 7'd56;
            4'd9:    ksl_rom_val = 7'd58;
            4'd10:   ksl_rom_val = 7'd59;
            4'd11:   ksl_rom_val = 7'd60;
            4'd12:   ksl_rom_val = 7'd61;
            4'd13:   ksl_rom_val = 7'd62;
            4'd14:   ksl_rom_val = 7'd63;
            default: ksl_rom_val = 7'd64;
        endcase
    end

    assign ksl_base = $signed({1'b0, ksl_rom_val, 2'b00})
                    - $signed({1'b0, 4'd8 - {1'b0, params.block}, 5'd0});
    assign ksl_full = ksl_base[9] ? 8'd0 : ksl_base[7:0];  // max 224 at block 7

    always_comb begin
        case (params.ksl)
            2'd0:    ksl_add = '0;
            2'd1:    ksl_add = ksl_full >> 1;  // 3 dB/octave
            2'd2:    ksl_add = ksl_full >> 2;  // 1.5 dB/octave
            default: ksl_add = ksl_full;       // 6 dB/octave
        endcase
    end

    assign split_bit = params.nts ? params.fnum[8] : params.fnum[9];
    assign key_code  = {params.block, split_bit};

    // port is 2 bits wide so the unshifted code saturates at 3
    assign rate_offset = params.ksr ? ((key_code > 4'd3) ? 2'd3 : key_code[1:0])
                                    : key_code[3:2];

endmodule

`default_nettype wire

// ==== common/op_param_if.sv ====
// ----------------------------------------------------------------------
// op_param_if, the envelope register group of one operator
// modports for the driving side and the decode, execute, result stages
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface op_param_if;
    import opl3_env_pkg::*;

    env_field_t ar;    // attack rate
    env_field_t dr;    // decay rate
    env_field_t sl;    // sustain level
    env_field_t rr;    // release rate
    tl_field_t  tl;    // total level
    logic       ksr;   // key scale rate
    ksl_field_t ksl;   // key scale level
    logic       egt;   // sustained envelope type
    logic       am;    // tremolo enable
    logic       dam;   // tremolo depth
    logic       nts;   // keyboard split select
    fnum_t      fnum;
    mult_t      mult;  // belongs to the group, no envelope use
    block_t     block;

    modport source (
        output ar, dr, sl, rr, tl, ksr, ksl, egt, am, dam, nts, fnum, mult, block
    );
    modport decode  (input ksr, ksl, nts, fnum, block);
    modport execute (input ar, dr, sl, rr, egt);
    modport result  (input tl, am, dam);

endinterface

`default_nettype wire

// ==== common/opl3_env_pkg.sv ====
// ----------------------------------------------------------------------
// operator envelope package
// field widths and types, envelope state enum, level and tremolo
// constants shared by the envelope stages
// ----------------------------------------------------------------------
`default_nettype none

package opl3_env_pkg;

    localparam int ENV_WIDTH           = 9;  // attenuation, 0.1875 dB steps
    localparam int REG_ENV_WIDTH       = 4;
    localparam int REG_TL_WIDTH        = 6;
    localparam int REG_KSL_WIDTH       = 2;
    localparam int REG_FNUM_WIDTH      = 10;
    localparam int REG_BLOCK_WIDTH     = 3;
    localparam int REG_MULT_WIDTH      = 4;
    localparam int KSL_ADD_WIDTH       = 8;
    localparam int AM_VAL_WIDTH        = 5;
    localparam int RATE_OVERFLOW_WIDTH = 3;  // up to 7 carries per tick
    localparam int RATE_OFFSET_WIDTH   = 2;
    localparam int RATE_COUNTER_WIDTH  = 15;
    localparam int EFF_RATE_WIDTH      = 6;
    localparam int EFF_RATE_MAX        = 60; // rates 60..63 behave alike

    typedef logic [ENV_WIDTH-1:0]           env_level_t;
    typedef logic [REG_ENV_WIDTH-1:0]       env_field_t;
    typedef logic [REG_TL_WIDTH-1:0]        tl_field_t;
    typedef logic [REG_KSL_WIDTH-1:0]       ksl_field_t;
    typedef logic [REG_FNUM_WIDTH-1:0]      fnum_t;
    typedef logic [REG_BLOCK_WIDTH-1:0]     block_t;
    typedef logic [REG_MULT_WIDTH-1:0]      mult_t;
    typedef logic [KSL_ADD_WIDTH-1:0]       ksl_add_t;
    typedef logic [AM_VAL_WIDTH-1:0]        am_val_t;
    typedef logic [RATE_OVERFLOW_WIDTH-1:0] rate_overflow_t;

    typedef enum logic [1:0] {
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

    localparam env_level_t ENV_SILENCE = 9'd511; // fully attenuated

    localparam am_val_t TREMOLO_DEEP_MAX    = 5'd26; // 4.8 dB
    localparam am_val_t TREMOLO_SHALLOW_MAX = 5'd6;  // 1 dB
    localparam int      TREMOLO_STEP_TICKS  = 64;    // sample ticks per step

endpackage

`default_nettype wire
